// ==== verif/ex_stage_patterns.txt ====
// grp sq pc cls f3 alt mul rd rs1 rs2 src_a src_b imm men mrd mdat wen wrd wdat
// then expected: result store_data pc_update dnpc (all hex, cls as op_class_e)
1 0 1000 1 0 0 0 1 2 3 1 2 12345000 0 0 0 0 0 0 12345000 2 0 0
1 0 2000 2 0 0 0 1 2 3 1 2 100 0 0 0 0 0 0 2100 2 0 0
1 0 1004 8 0 0 0 1 2 3 ffffffffffffffff 2 5 0 0 0 0 0 0 4 2 0 0
1 0 1008 9 0 1 0 1 2 3 5 7 0 0 0 0 0 0 0 fffffffffffffffe 7 0 0
1 0 100c 9 5 1 0 1 2 3 8000000000000000 3f 0 0 0 0 0 0 0 ffffffffffffffff 3f 0 0
1 0 1010 9 2 0 0 1 2 3 ffffffffffffffff 1 0 0 0 0 0 0 0 1 1 0 0
1 0 1014 9 3 0 0 1 2 3 ffffffffffffffff 1 0 0 0 0 0 0 0 0 1 0 0
1 0 1018 8 1 0 0 1 2 3 1 2 3f 0 0 0 0 0 0 8000000000000000 2 0 0
1 0 101c b 0 0 0 1 2 3 7fffffff 1 0 0 0 0 0 0 0 ffffffff80000000 1 0 0
1 0 1020 a 5 1 0 1 2 3 80000000 2 4 0 0 0 0 0 0 fffffffff8000000 2 0 0
1 0 1024 b 0 1 0 1 2 3 0 1 0 0 0 0 0 0 0 ffffffffffffffff 1 0 0
1 0 1028 a 1 0 0 1 2 3 1 2 1f 0 0 0 0 0 0 ffffffff80000000 2 0 0
2 0 2000 9 0 0 0 1 3 4 1 2 0 1 3 10 1 4 20 30 20 0 0
2 0 2004 9 0 0 0 1 5 5 1 2 0 1 5 100 1 5 200 200 100 0 0
2 0 2008 9 0 0 0 1 0 0 0 0 0 1 0 55 1 0 66 0 0 0 0
2 0 200c 8 0 0 0 1 6 7 1 9 2 1 7 77 1 6 40 42 9 0 0
2 0 2010 7 0 0 0 0 8 9 1000 abc 8 1 9 1234 0 0 0 1008 1234 0 0
3 0 4000 5 0 0 0 0 1 2 5 5 40 0 0 0 0 0 0 0 5 1 4040
3 0 4000 5 1 0 0 0 1 2 5 5 40 0 0 0 0 0 0 0 5 0 0
3 0 4000 5 4 0 0 0 1 2 ffffffffffffffff 1 40 0 0 0 0 0 0 0 1 1 4040
3 0 4000 5 5 0 0 0 1 2 ffffffffffffffff 1 40 0 0 0 0 0 0 0 1 0 0
3 0 4000 5 6 0 0 0 1 2 ffffffffffffffff 1 40 0 0 0 0 0 0 0 1 0 0
3 0 4000 5 7 0 0 0 1 2 ffffffffffffffff 1 40 0 0 0 0 0 0 0 1 1 4040
3 0 4000 5 0 0 0 0 1 2 1 ffffffffffffffff 40 0 0 0 0 0 0 0 ffffffffffffffff 0 0
3 0 4000 5 1 0 0 0 1 2 1 ffffffffffffffff 40 0 0 0 0 0 0 0 ffffffffffffffff 1 4040
3 0 4000 5 4 0 0 0 1 2 1 ffffffffffffffff 40 0 0 0 0 0 0 0 ffffffffffffffff 0 0
3 0 4000 5 5 0 0 0 1 2 1 ffffffffffffffff 40 0 0 0 0 0 0 0 ffffffffffffffff 1 4040
3 0 4000 5 6 0 0 0 1 2 1 ffffffffffffffff 40 0 0 0 0 0 0 0 ffffffffffffffff 1 4040
3 0 4000 5 7 0 0 0 1 2 1 ffffffffffffffff 40 0 0 0 0 0 0 0 ffffffffffffffff 0 0
3 0 5000 3 0 0 0 1 0 0 0 0 100 0 0 0 0 0 0 5004 0 1 5100
3 0 6000 4 0 0 0 1 2 0 7001 0 10 0 0 0 0 0 0 6004 0 1 7010
4 0 7000 9 0 0 1 5 1 2 ffffffffffffffff 3 0 0 0 0 0 0 0 fffffffffffffffd 3 0 0
4 0 7004 9 0 0 1 5 1 2 123456789 0 0 0 0 0 0 0 0 0 0 0 0
4 0 7008 9 0 0 1 5 1 2 ffffffff ffffffff 0 0 0 0 0 0 0 fffffffe00000001 ffffffff 0 0
4 0 700c b 0 0 1 5 1 2 fffffffe 3 0 0 0 0 0 0 0 fffffffffffffffa 3 0 0
4 0 7010 b 0 0 1 5 1 2 40000000 2 0 0 0 0 0 0 0 ffffffff80000000 2 0 0
4 0 7014 9 0 0 1 5 3 4 0 0 0 1 3 6 1 4 7 2a 7 0 0
4 0 7018 8 0 0 0 1 2 3 5 0 1 0 0 0 0 0 0 6 0 0 0
5 1 8000 8 0 0 0 1 2 3 1 2 1 0 0 0 0 0 0 0 0 0 0
5 0 8004 8 0 0 0 1 2 3 a 2 1 0 0 0 0 0 0 b 2 0 0
5 1 8008 9 0 0 1 5 1 2 3 3 0 0 0 0 0 0 0 0 0 0 0
5 0 800c 9 0 0 1 5 1 2 3 3 0 0 0 0 0 0 0 9 3 0 0
5 0 8010 9 0 1 0 1 2 3 3 3 0 0 0 0 0 0 0 0 3 0 0

// ==== sim.f ====
logic/ex_pkg.sv
logic/ex_op_if.sv
logic/ex_stage_reg.sv
logic/ex_forward.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_multiplier.sv
logic/ex_stage.sv
verif/ex_stage_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = ex_stage_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/ex_stage_tb.sv ====
`timescale 1ns/1ns

module ex_stage_tb import ex_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_PAT    = 43;
    // hex words per pattern line
    localparam int NF         = 23;
    localparam int NUM_GRP    = 6;
    localparam int WD_CYCLES  = NUM_PAT * (MUL_STEPS + 20);
    // the last held item may still be a full multiply
    localparam int DRAIN_CYCLES = MUL_STEPS + 20;

    // column index within a pattern line
    localparam int F_GRP  = 0;
    localparam int F_SQ   = 1;
    localparam int F_PC   = 2;
    localparam int F_CLS  = 3;
    localparam int F_F3   = 4;
    localparam int F_ALT  = 5;
    localparam int F_MUL  = 6;
    localparam int F_RD   = 7;
    localparam int F_RS1  = 8;
    localparam int F_RS2  = 9;
    localparam int F_A    = 10;
    localparam int F_B    = 11;
    localparam int F_IMM  = 12;
    localparam int F_MEN  = 13;
    localparam int F_MRD  = 14;
    localparam int F_MDAT = 15;
    localparam int F_WEN  = 16;
    localparam int F_WRD  = 17;
    localparam int F_WDAT = 18;
    localparam int F_RES  = 19;
    localparam int F_ST   = 20;
    localparam int F_PCU  = 21;
    localparam int F_DNPC = 22;

    logic clk;
    logic arst_n;
    logic flush;
    logic valid_in;
    logic ready_in;
    logic [XLEN-1:0] pc_in;
    op_class_e op_class_in;
    logic [2:0] funct3_in;
    logic alt_in;
    logic is_mul_in;
    logic [REG_ADDR_W-1:0] rd_in;
    logic [REG_ADDR_W-1:0] rs1_in;
    logic [REG_ADDR_W-1:0] rs2_in;
    logic [XLEN-1:0] src_a_in;
    logic [XLEN-1:0] src_b_in;
    logic [XLEN-1:0] imm_in;
    logic mem_fwd_en;
    logic [REG_ADDR_W-1:0] mem_fwd_rd;
    logic [XLEN-1:0] mem_fwd_data;
    logic wb_fwd_en;
    logic [REG_ADDR_W-1:0] wb_fwd_rd;
    logic [XLEN-1:0] wb_fwd_data;
    logic valid_out;
    logic ready_out;
    logic [XLEN-1:0] pc_out;
    op_class_e op_class_out;
    logic [REG_ADDR_W-1:0] rd_out;
    logic [XLEN-1:0] result_out;
    logic [XLEN-1:0] store_data_out;
    logic pc_update;
    logic [XLEN-1:0] dnpc;

    logic [63:0] pat [0:NUM_PAT*NF-1];
    // pattern indices expected to leave, in order
    int exp_idx [0:NUM_PAT-1];
    int num_exp;
    int exp_ptr;
    int err_count;
    int grp_exp  [0:NUM_GRP-1];
    int grp_seen [0:NUM_GRP-1];
    int grp_err  [0:NUM_GRP-1];
    int cur_pat;
    int cur_grp;
    int mon_base;

    ex_stage DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .valid_in       (valid_in),
        .ready_in       (ready_in),
        .pc_in          (pc_in),
        .op_class_in    (op_class_in),
        .funct3_in      (funct3_in),
        .alt_in         (alt_in),
        .is_mul_in      (is_mul_in),
        .rd_in          (rd_in),
        .rs1_in         (rs1_in),
        .rs2_in         (rs2_in),
        .src_a_in       (src_a_in),
        .src_b_in       (src_b_in),
        .imm_in         (imm_in),
        .mem_fwd_en     (mem_fwd_en),
        .mem_fwd_rd     (mem_fwd_rd),
        .mem_fwd_data   (mem_fwd_data),
        .wb_fwd_en      (wb_fwd_en),
        .wb_fwd_rd      (wb_fwd_rd),
        .wb_fwd_data    (wb_fwd_data),
        .valid_out      (valid_out),
        .ready_out      (ready_out),
        .pc_out         (pc_out),
        .op_class_out   (op_class_out),
        .rd_out         (rd_out),
        .result_out     (result_out),
        .store_data_out (store_data_out),
        .pc_update      (pc_update),
        .dnpc           (dnpc)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic string group_name(input int g);
        case (g)
            1:       return "alu classes";
            2:       return "forwarding";
            3:       return "branches and jumps";
            4:       return "multiply";
            5:       return "flush";
            default: return "unknown";
        endcase
    endfunction

    task automatic count_error();
        err_count++;
        grp_err[cur_grp]++;
    endtask

    // single compare point for every output value
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h (pattern %0d)", name, got, exp, cur_pat);
            count_error();
        end
    endtask

    // writer-stage values belong to the item held in the stage
    task automatic drive_forwarding(input int idx);
        int b;
        b = idx * NF;
        if (idx < 0) begin
            mem_fwd_en = 1'b0;
            wb_fwd_en  = 1'b0;
        end else begin
            mem_fwd_en   = pat[b+F_MEN][0];
            mem_fwd_rd   = pat[b+F_MRD][REG_ADDR_W-1:0];
            mem_fwd_data = pat[b+F_MDAT];
            wb_fwd_en    = pat[b+F_WEN][0];
            wb_fwd_rd    = pat[b+F_WRD][REG_ADDR_W-1:0];
            wb_fwd_data  = pat[b+F_WDAT];
        end
    endtask

    task automatic apply_pattern(input int idx);
        int b;
        b = idx * NF;
        pc_in       = pat[b+F_PC];
        op_class_in = op_class_e'(pat[b+F_CLS][3:0]);
        funct3_in   = pat[b+F_F3][2:0];
        alt_in      = pat[b+F_ALT][0];
        is_mul_in   = pat[b+F_MUL][0];
        rd_in       = pat[b+F_RD][REG_ADDR_W-1:0];
        rs1_in      = pat[b+F_RS1][REG_ADDR_W-1:0];
        rs2_in      = pat[b+F_RS2][REG_ADDR_W-1:0];
        src_a_in    = pat[b+F_A];
        src_b_in    = pat[b+F_B];
        imm_in      = pat[b+F_IMM];
    endtask

    // back-pressure about a quarter of the cycles
    function automatic logic random_ready();
        return ($urandom % 4) != 0;
    endfunction

    // monitor, sampled at the edge where the item leaves
    always @(posedge clk) begin
        if (arst_n && pc_update && !ready_out) begin
            $display("pc_update was high while ready_out was low");
            count_error();
        end
        if (arst_n && valid_out && ready_out) begin
            if (exp_ptr >= num_exp) begin
                $display("an extra item left the stage with pc %h", pc_out);
                count_error();
            end else begin
                cur_pat  = exp_idx[exp_ptr];
                mon_base = cur_pat * NF;
                cur_grp  = int'(pat[mon_base+F_GRP]);
                check_value("pc_out", pc_out, pat[mon_base+F_PC]);
                check_value("op_class_out", 64'(op_class_out),
                            64'(pat[mon_base+F_CLS][3:0]));
                check_value("rd_out", 64'(rd_out), 64'(pat[mon_base+F_RD][REG_ADDR_W-1:0]));
                // branch result is don't-care
                if (pat[mon_base+F_CLS][3:0] != 4'(OP_BRANCH)) begin
                    check_value("result_out", result_out, pat[mon_base+F_RES]);
                end
                check_value("store_data_out", store_data_out, pat[mon_base+F_ST]);
                check_value("pc_update", 64'(pc_update), pat[mon_base+F_PCU]);
                if (pat[mon_base+F_PCU][0]) begin
                    check_value("dnpc", dnpc, pat[mon_base+F_DNPC]);
                end
                grp_seen[cur_grp]++;
                if (grp_seen[cur_grp] == grp_exp[cur_grp]) begin
                    $display("group %0d (%s) done: %0d items, %0d errors", cur_grp,
                             group_name(cur_grp), grp_seen[cur_grp], grp_err[cur_grp]);
                end
                exp_ptr++;
            end
        end
    end

    // watchdog sized from the pattern count
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int held;
        int n_bub;
        int accepted;
        int drain_cycles;
        void'($urandom(30868));
        clk          = 1'b0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        valid_in     = 1'b0;
        ready_out    = 1'b0;
        pc_in        = '0;
        op_class_in  = OP_NONE;
        funct3_in    = '0;
        alt_in       = 1'b0;
        is_mul_in    = 1'b0;
        rd_in        = '0;
        rs1_in       = '0;
        rs2_in       = '0;
        src_a_in     = '0;
        src_b_in     = '0;
        imm_in       = '0;
        mem_fwd_en   = 1'b0;
        mem_fwd_rd   = '0;
        mem_fwd_data = '0;
        wb_fwd_en    = 1'b0;
        wb_fwd_rd    = '0;
        wb_fwd_data  = '0;
        num_exp      = 0;
        exp_ptr      = 0;
        err_count    = 0;
        cur_pat      = 0;
        cur_grp      = 0;
        held         = -1;
        for (int g = 0; g < NUM_GRP; g++) begin
            grp_exp[g]  = 0;
            grp_seen[g] = 0;
            grp_err[g]  = 0;
        end

        $readmemh("verif/ex_stage_patterns.txt", pat);
        // squashed patterns never leave
        for (int i = 0; i < NUM_PAT; i++) begin
            if (!pat[i*NF+F_SQ][0]) begin
                exp_idx[num_exp] = i;
                num_exp++;
                grp_exp[int'(pat[i*NF+F_GRP])]++;
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < NUM_PAT; i++) begin
            n_bub = $urandom % 3;
            repeat (n_bub) begin
                @(negedge clk);
                valid_in  = 1'b0;
                ready_out = random_ready();
                drive_forwarding(held);
            end
            @(negedge clk);
            apply_pattern(i);
            valid_in  = 1'b1;
            ready_out = random_ready();
            drive_forwarding(held);
            accepted = 0;
            while (accepted == 0) begin
                @(posedge clk);
                if (ready_in) begin
                    accepted = 1;
                end else begin
                    @(negedge clk);
                    ready_out = random_ready();
                    drive_forwarding(held);
                end
            end
            held = i;
            if (pat[i*NF+F_SQ][0]) begin
                // hold the item with ready_out low, then squash it
                @(negedge clk);
                valid_in  = 1'b0;
                ready_out = 1'b0;
                drive_forwarding(held);
                if (pat[i*NF+F_MUL][0]) begin
                    // let the multiply get partway
                    repeat (10) @(negedge clk);
                end
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                held  = -1;
            end
        end

        // drain
        @(negedge clk);
        valid_in  = 1'b0;
        ready_out = 1'b1;
        drive_forwarding(held);
        drain_cycles = 0;
        while ((exp_ptr < num_exp) && (drain_cycles < DRAIN_CYCLES)) begin
            @(posedge clk);
            drain_cycles++;
        end
        repeat (10) @(posedge clk);

        if (exp_ptr < num_exp) begin
            $display("%0d expected items never left the stage", num_exp - exp_ptr);
            err_count++;
        end
        $display("checked %0d of %0d items, %0d errors", exp_ptr, num_exp, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    // from decode
    input  logic                  valid_in,
    output logic                  ready_in,
    input  logic [XLEN-1:0]       pc_in,
    input  op_class_e             op_class_in,
    input  logic [2:0]            funct3_in,
    input  logic                  alt_in,
    input  logic                  is_mul_in,
    input  logic [REG_ADDR_W-1:0] rd_in,
    input  logic [REG_ADDR_W-1:0] rs1_in,
    input  logic [REG_ADDR_W-1:0] rs2_in,
    input  logic [XLEN-1:0]       src_a_in,
    input  logic [XLEN-1:0]       src_b_in,
    input  logic [XLEN-1:0]       imm_in,
    // writers further down the pipe
    input  logic                  mem_fwd_en,
    input  logic [REG_ADDR_W-1:0] mem_fwd_rd,
    input  logic [XLEN-1:0]       mem_fwd_data,
    input  logic                  wb_fwd_en,
    input  logic [REG_ADDR_W-1:0] wb_fwd_rd,
    input  logic [XLEN-1:0]       wb_fwd_data,
    // to memory stage
    output logic                  valid_out,
    input  logic                  ready_out,
    output logic [XLEN-1:0]       pc_out,
    output op_class_e             op_class_out,
    output logic [REG_ADDR_W-1:0] rd_out,
    output logic [XLEN-1:0]       result_out,
    output logic [XLEN-1:0]       store_data_out,
    // fetch redirect
    output logic                  pc_update,
    output logic [XLEN-1:0]       dnpc
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_result;
    logic            redirect;
    logic [XLEN-1:0] target;
    logic            mul_start;
    logic            mul_clear;
    logic            mul_busy;
    logic            mul_done;
    logic [XLEN-1:0] mul_product;
    logic            mul_stall;
    logic            advance;

    ex_op_if op_bus ();

    ex_stage_reg u_stage_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .load        (ready_in),
        .valid_in    (valid_in),
        .pc_in       (pc_in),
        .op_class_in (op_class_in),
        .funct3_in   (funct3_in),
        .alt_in      (alt_in),
        .is_mul_in   (is_mul_in),
        .rd_in       (rd_in),
        .rs1_in      (rs1_in),
        .rs2_in      (rs2_in),
        .src_a_in    (src_a_in),
        .src_b_in    (src_b_in),
        .imm_in      (imm_in),
        .op          (op_bus.stage)
    );

    ex_forward u_forward (
        .op           (op_bus.consume),
        .mem_fwd_en   (mem_fwd_en),
        .mem_fwd_rd   (mem_fwd_rd),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_en    (wb_fwd_en),
        .wb_fwd_rd    (wb_fwd_rd),
        .wb_fwd_data  (wb_fwd_data),
        .src1         (src1),
        .src2         (src2)
    );

    ex_alu u_alu (
        .op     (op_bus.consume),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    ex_branch u_branch (
        .op       (op_bus.consume),
        .src1     (src1),
        .src2     (src2),
        .redirect (redirect),
        .target   (target)
    );

    ex_multiplier u_mul (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (mul_start),
        .clear        (mul_clear),
        .word         (op_bus.op_class == OP_REGW),
        .multiplicand (src1),
        .multiplier   (src2),
        .busy         (mul_busy),
        .done         (mul_done),
        .product      (mul_product)
    );

    // held multiply without a result blocks the stage
    assign mul_stall = op_bus.valid && op_bus.is_mul && !mul_done;

    // one start per held multiply
    assign mul_start = op_bus.valid && op_bus.is_mul && !mul_busy && !mul_done;

    assign ready_in  = ready_out && !mul_stall;
    assign valid_out = op_bus.valid && !mul_stall;

    // item leaves on this edge
    assign advance = valid_out && ready_out;

    // done is dropped once the item is gone or squashed
    assign mul_clear = advance || flush;

    assign pc_out         = op_bus.pc;
    assign op_class_out   = op_bus.op_class;
    assign rd_out         = op_bus.rd;
    assign result_out     = op_bus.is_mul ? mul_product : alu_result;
    assign store_data_out = src2;

    // redirect only as the item actually leaves
    assign pc_update = advance && redirect;
    assign dnpc      = target;

endmodule

// ==== logic/ex_multiplier.sv ====
`timescale 1ns/1ns

module ex_multiplier import ex_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  logic            clear,
    input  logic            word,
    input  logic [XLEN-1:0] multiplicand,
    input  logic [XLEN-1:0] multiplier,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] product
);

    logic [MUL_CNT_W-1:0] cnt;
    logic [XLEN-1:0]      acc;
    // multiplicand moves left, multiplier moves right
    logic [XLEN-1:0]      mcand;
    logic [XLEN-1:0]      mplier;
    logic                 word_q;

    // control, clear aborts a run and drops done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (clear) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            cnt  <= word ? MUL_CNT_W'(MUL_STEPS_WORD) : MUL_CNT_W'(MUL_STEPS);
        end else if (busy) begin
            cnt <= cnt - MUL_CNT_W'(1);
            // last step
            if (cnt == MUL_CNT_W'(1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start && !clear) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplier;
            word_q <= word;
        end else if (busy && !clear) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // low half only; signs need no care modulo 2^XLEN
    assign product = word_q ? {{(XLEN-WORD_W){acc[WORD_W-1]}}, acc[WORD_W-1:0]} : acc;

endmodule

// ==== logic/ex_branch.sv ====
`timescale 1ns/1ns

module ex_branch import ex_pkg::*; (
    ex_op_if.consume        op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic            redirect,
    output logic [XLEN-1:0] target
);

    logic            taken;
    logic            is_jump;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] reg_rel;

    // branch condition from funct3
    always_comb begin
        case (branch_funct_e'(op.funct3))
            BEQ:     taken = (src1 == src2);
            BNE:     taken = (src1 != src2);
            BLT:     taken = $signed(src1) < $signed(src2);
            BGE:     taken = $signed(src1) >= $signed(src2);
            BLTU:    taken = src1 < src2;
            BGEU:    taken = src1 >= src2;
            // funct3 010 / 011 never branch
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (op.op_class == OP_JAL) || (op.op_class == OP_JALR);

    // no prediction here, every taken branch redirects
    assign redirect = is_jump || ((op.op_class == OP_BRANCH) && taken);

    // branch and jal are pc-relative
    assign pc_rel = op.pc + op.imm;

    // jalr drops bit 0 of the sum
    assign reg_rel = src1 + op.imm;

    assign target = (op.op_class == OP_JALR) ? {reg_rel[XLEN-1:1], 1'b0} : pc_rel;

endmodule

// ==== logic/ex_alu.sv ====
`timescale 1ns/1ns

module ex_alu import ex_pkg::*; (
    ex_op_if.consume        op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic               is_word;
    logic               is_arith;
    logic               use_sub;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    diff;
    logic [XLEN-1:0]    srl_src;
    logic [XLEN-1:0]    sra_src;
    logic [XLEN-1:0]    raw;

    // operand pick per class
    always_comb begin
        op_a = src1;
        op_b = op.imm;
        case (op.op_class)
            OP_LUI: begin
                op_a = '0;
            end
            OP_AUIPC: begin
                op_a = op.pc;
            end
            OP_JAL, OP_JALR: begin
                // link value is pc + 4
                op_a = op.pc;
                op_b = XLEN'(PC_STEP);
            end
            OP_REG, OP_REGW: begin
                op_b = src2;
            end
            default: begin
                // load, store and the immediate forms take src1 + imm
                op_a = src1;
            end
        endcase
    end

    assign is_word  = (op.op_class == OP_IMMW) || (op.op_class == OP_REGW);
    assign is_arith = op.op_class inside {OP_IMM, OP_REG, OP_IMMW, OP_REGW};

    // addi has no subtract form
    assign use_sub = op.alt && ((op.op_class == OP_REG) || (op.op_class == OP_REGW));

    // word shifts ignore bit 5
    assign shamt = is_word ? SHAMT_W'(op_b[SHAMT_W_WORD-1:0]) : op_b[SHAMT_W-1:0];

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // right shift sources, word forms only see the low half
    assign srl_src = is_word ? {{(XLEN-WORD_W){1'b0}}, op_a[WORD_W-1:0]} : op_a;
    assign sra_src = is_word ? {{(XLEN-WORD_W){op_a[WORD_W-1]}}, op_a[WORD_W-1:0]} : op_a;

    always_comb begin
        // plain add for address and link classes
        raw = sum;
        if (is_arith) begin
            case (alu_funct_e'(op.funct3))
                ADD:     raw = use_sub ? diff : sum;
                SLL:     raw = op_a << shamt;
                SLT:     raw = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                SLTU:    raw = {{(XLEN-1){1'b0}}, op_a < op_b};
                XOR:     raw = op_a ^ op_b;
                SRL_SRA: raw = op.alt ? XLEN'($signed(sra_src) >>> shamt) : srl_src >> shamt;
                OR:      raw = op_a | op_b;
                AND:     raw = op_a & op_b;
                default: raw = sum;
            endcase
        end
    end

    // word results are sign-extended from bit 31
    assign result = is_word ? {{(XLEN-WORD_W){raw[WORD_W-1]}}, raw[WORD_W-1:0]} : raw;

endmodule

// ==== logic/ex_forward.sv ====
`timescale 1ns/1ns

module ex_forward import ex_pkg::*; (
    ex_op_if.consume              op,
    input  logic                  mem_fwd_en,
    input  logic [REG_ADDR_W-1:0] mem_fwd_rd,
    input  logic [XLEN-1:0]       mem_fwd_data,
    input  logic                  wb_fwd_en,
    input  logic [REG_ADDR_W-1:0] wb_fwd_rd,
    input  logic [XLEN-1:0]       wb_fwd_data,
    output logic [XLEN-1:0]       src1,
    output logic [XLEN-1:0]       src2
);

    logic uses_rs2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // only these classes read rs2
    assign uses_rs2 = op.op_class inside {OP_BRANCH, OP_STORE, OP_REG, OP_REGW};

    // x0 is never forwarded
    assign mem_hit1 = mem_fwd_en && (mem_fwd_rd == op.rs1) && (op.rs1 != '0);
    assign wb_hit1  = wb_fwd_en && (wb_fwd_rd == op.rs1) && (op.rs1 != '0);
    assign mem_hit2 = uses_rs2 && mem_fwd_en && (mem_fwd_rd == op.rs2) && (op.rs2 != '0);
    assign wb_hit2  = uses_rs2 && wb_fwd_en && (wb_fwd_rd == op.rs2) && (op.rs2 != '0);

    // memory stage is newer, so it beats write-back
    assign src1 = mem_hit1 ? mem_fwd_data :
                  wb_hit1  ? wb_fwd_data  : op.src_a;
    assign src2 = mem_hit2 ? mem_fwd_data :
                  wb_hit2  ? wb_fwd_data  : op.src_b;

endmodule

// ==== logic/ex_stage_reg.sv ====
`timescale 1ns/1ns

module ex_stage_reg import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  load,
    input  logic                  valid_in,
    input  logic [XLEN-1:0]       pc_in,
    input  op_class_e             op_class_in,
    input  logic [2:0]            funct3_in,
    input  logic                  alt_in,
    input  logic                  is_mul_in,
    input  logic [REG_ADDR_W-1:0] rd_in,
    input  logic [REG_ADDR_W-1:0] rs1_in,
    input  logic [REG_ADDR_W-1:0] rs2_in,
    input  logic [XLEN-1:0]       src_a_in,
    input  logic [XLEN-1:0]       src_b_in,
    input  logic [XLEN-1:0]       imm_in,
    ex_op_if.stage                op
);

    // valid bit, flush wins over load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op.valid <= 1'b0;
        end else if (flush) begin
            op.valid <= 1'b0;
        end else if (load) begin
            // a bubble loads as valid low
            op.valid <= valid_in;
        end
    end

    // payload, only meaningful while valid is set
    always_ff @(posedge clk) begin
        if (load && !flush) begin
            op.pc       <= pc_in;
            op.op_class <= op_class_in;
            op.funct3   <= funct3_in;
            op.alt      <= alt_in;
            op.is_mul   <= is_mul_in;
            op.rd       <= rd_in;
            op.rs1      <= rs1_in;
            op.rs2      <= rs2_in;
            op.src_a    <= src_a_in;
            op.src_b    <= src_b_in;
            op.imm      <= imm_in;
        end
    end

endmodule

// ==== logic/ex_op_if.sv ====
`timescale 1ns/1ns

interface ex_op_if import ex_pkg::*; ();

    // instruction held in the execute stage
    logic                  valid;
    logic [XLEN-1:0]       pc;
    op_class_e             op_class;
    logic [2:0]            funct3;
    // sub / sra select
    logic                  alt;
    logic                  is_mul;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    // register values as read in decode, before forwarding
    logic [XLEN-1:0]       src_a;
    logic [XLEN-1:0]       src_b;
    logic [XLEN-1:0]       imm;

    // stage register side
    modport stage (
        output valid, pc, op_class, funct3, alt, is_mul,
        output rd, rs1, rs2, src_a, src_b, imm
    );

    // forwarding, alu, branch and top-level control
    modport consume (
        input valid, pc, op_class, funct3, alt, is_mul,
        input rd, rs1, rs2, src_a, src_b, imm
    );

endinterface

// ==== logic/ex_pkg.sv ====
package ex_pkg;

    // datapath and address width
    localparam int XLEN = 64;

    // width of the word-sized operations
    localparam int WORD_W = 32;

    // step from one instruction to the next, in bytes
    localparam int PC_STEP = 4;

    // register file index
    localparam int REG_ADDR_W = 5;

    // shift amounts, full and word
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_W_WORD = 5;

    // shift-add iterations, one multiplier bit each
    localparam int MUL_STEPS      = 64;
    localparam int MUL_STEPS_WORD = 32;

    // step counter must hold MUL_STEPS itself
    localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

    // operation class delivered by decode
    typedef enum logic [3:0] {
        OP_NONE   = 4'd0,
        OP_LUI    = 4'd1,
        OP_AUIPC  = 4'd2,
        OP_JAL    = 4'd3,
        OP_JALR   = 4'd4,
        OP_BRANCH = 4'd5,
        OP_LOAD   = 4'd6,
        OP_STORE  = 4'd7,
        OP_IMM    = 4'd8,
        OP_REG    = 4'd9,
        OP_IMMW   = 4'd10,
        OP_REGW   = 4'd11
    } op_class_e;

    // funct3 of the integer ops, RISC-V encoding
    typedef enum logic [2:0] {
        ADD     = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } alu_funct_e;

    // funct3 of the conditional branches; 010 and 011 unused
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_funct_e;

endpackage
